// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := back_end_tb
FILELIST  := project.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: project.f
verilog/backend_pkg.sv
verilog/gpr_stage.sv
verilog/exec_unit.sv
verilog/lsu.sv
verilog/writeback_arb.sv
verilog/back_end.sv
verif/back_end_tb.sv

// File: verif/back_end_tb.sv
module back_end_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import backend_pkg::*;

	localparam int pool_regs = 6;
	localparam int timeout = 2000;
	localparam int num_instrs = 3000;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic in_valid = 1'b0;
	logic in_ready;
	logic [1:0] in_warp = '0;
	logic [31:0] in_pc = '0;
	instr_t in_instr = '0;
	logic dc_req_valid;
	logic dc_req_ready = 1'b0;
	logic dc_req_we;
	logic [31:0] dc_req_addr;
	logic [31:0] dc_req_wdata;
	logic dc_rsp_valid = 1'b0;
	logic dc_rsp_ready;
	logic [31:0] dc_rsp_data = '0;
	logic wb_valid;
	logic [1:0] wb_warp;
	logic [31:0] wb_pc;
	logic [4:0] wb_rd;
	logic [31:0] wb_data;

	// Reference model state and expected writebacks per warp and register
	logic [31:0] model_rf [4][32] = '{default: '0};
	logic [31:0] model_mem [64] = '{default: '0};
	bit exp_valid [4][32] = '{default: 1'b0};
	logic [31:0] exp_data [4][32];
	logic [31:0] exp_pc [4][32];
	int outstanding = 0;
	logic [31:0] pc_next = '0;
	int last_target = 0;

	// Data cache model
	logic [31:0] cache_mem [64] = '{default: '0};
	logic [31:0] rsp_data_q [$];
	int rsp_due_q [$];
	int cycle = 0;
	bit req_take = 1'b0;
	bit rsp_take = 1'b0;
	logic req_we;
	logic [31:0] req_addr;
	logic [31:0] req_wdata;

	back_end #(.num_warps(4)) u_back_end (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_ready(in_ready), .in_warp(in_warp),
		.in_pc(in_pc), .in_instr(in_instr),
		.dc_req_valid(dc_req_valid), .dc_req_ready(dc_req_ready), .dc_req_we(dc_req_we),
		.dc_req_addr(dc_req_addr), .dc_req_wdata(dc_req_wdata),
		.dc_rsp_valid(dc_rsp_valid), .dc_rsp_ready(dc_rsp_ready), .dc_rsp_data(dc_rsp_data),
		.wb_valid(wb_valid), .wb_warp(wb_warp), .wb_pc(wb_pc),
		.wb_rd(wb_rd), .wb_data(wb_data)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("error at %0t: %s is 0x%08h, expected 0x%08h",
				$time, name, got, exp));
	endtask

	function automatic logic [31:0] alu_model(opcode_t op, logic [31:0] a, logic [31:0] b);
		case (op)
			op_sub: return a - b;
			op_and: return a & b;
			op_or:  return a | b;
			op_xor: return a ^ b;
			op_sll: return a << b[4:0];
			op_srl: return a >> b[4:0];
			op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return a + b;
		endcase
	endfunction

	// Small pool so that hazards are frequent
	function automatic logic [4:0] pick_reg();
		if ($urandom % 8 == 0)
			return 5'd0;
		else
			return 5'(1 + $urandom % pool_regs);
	endfunction

	task automatic make_random_instr(output logic [1:0] w, output instr_t ins);
		logic [31:0] base;
		int target;
		int off;
		ins = '0;
		w = 2'($urandom % 4);
		if ($urandom % 10 < 6) begin
			ins.alu.opcode = opcode_t'(4'($urandom % 9));
			ins.alu.rd = pick_reg();
			ins.alu.rs1 = pick_reg();
			ins.alu.rs2 = pick_reg();
			ins.alu.imm = 13'($urandom);
		end else begin
			ins.mem.opcode = ($urandom % 2 == 0) ? op_lw : op_sw;
			ins.mem.rd_rs2 = pick_reg();
			ins.mem.rs1 = pick_reg();
			// Aim the address into the 64-word window and often reuse the last one
			base = model_rf[w][ins.mem.rs1];
			if ($urandom % 4 == 0)
				target = last_target;
			else
				target = int'($urandom % 64);
			last_target = target;
			off = target - int'(base);
			if (off < -131072 || off > 131071) begin
				ins.mem.rs1 = 5'd0;
				off = target;
			end
			ins.mem.offset = off[17:0];
		end
	endtask

	task automatic send_instr(input logic [1:0] w, input instr_t ins);
		int waited;
		in_valid <= 1'b1;
		in_warp <= w;
		in_pc <= pc_next;
		in_instr <= ins;
		pc_next = pc_next + 32'd4;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!in_ready && waited < timeout);
		if (!in_ready)
			fail_run("issue port stalled past the timeout");
		@(posedge clk);
	endtask

	task automatic execute_issue();
		logic [1:0] w;
		opcode_t op;
		logic [4:0] rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] res;
		bit writes;
		w = in_warp;
		op = in_instr.alu.opcode;
		if (is_mem_op(op)) begin
			a = model_rf[w][in_instr.mem.rs1];
			addr = a + {{(xlen-off_w){in_instr.mem.offset[off_w-1]}}, in_instr.mem.offset};
			rd = in_instr.mem.rd_rs2;
			res = model_mem[addr[5:0]];
			writes = (op == op_lw);
			if (op == op_sw)
				model_mem[addr[5:0]] = model_rf[w][rd];
		end else begin
			a = model_rf[w][in_instr.alu.rs1];
			if (op == op_addi)
				b = {{(xlen-imm_w){in_instr.alu.imm[imm_w-1]}}, in_instr.alu.imm};
			else
				b = model_rf[w][in_instr.alu.rs2];
			res = alu_model(op, a, b);
			rd = in_instr.alu.rd;
			writes = 1'b1;
		end
		if (writes && rd != 5'd0) begin
			if (exp_valid[w][rd])
				fail_run($sformatf("warp %0d register %0d issued while still pending", w, rd));
			model_rf[w][rd] = res;
			exp_valid[w][rd] = 1'b1;
			exp_data[w][rd] = res;
			exp_pc[w][rd] = in_pc;
			outstanding++;
		end
	endtask

	task automatic retire_wb();
		if (wb_rd == 5'd0)
			fail_run("writeback to register 0");
		if (!exp_valid[wb_warp][wb_rd])
			fail_run($sformatf("writeback to warp %0d register %0d with nothing outstanding",
				wb_warp, wb_rd));
		check_value("wb_pc", wb_pc, exp_pc[wb_warp][wb_rd]);
		check_value("wb_data", wb_data, exp_data[wb_warp][wb_rd]);
		exp_valid[wb_warp][wb_rd] = 1'b0;
		outstanding--;
	endtask

	// Writebacks free a slot before an issue in the same cycle may claim it
	always @(negedge clk) begin
		if (rst_n) begin
			if (wb_valid)
				retire_wb();
			if (in_valid && in_ready)
				execute_issue();
		end
	end

	always @(negedge clk) begin
		req_take = rst_n && dc_req_valid && dc_req_ready;
		rsp_take = rst_n && dc_rsp_valid && dc_rsp_ready;
		req_we = dc_req_we;
		req_addr = dc_req_addr;
		req_wdata = dc_req_wdata;
		if (req_take && dc_req_addr >= 32'd64)
			fail_run($sformatf("data cache address 0x%08h outside the window", dc_req_addr));
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			dc_req_ready <= 1'b0;
			dc_rsp_valid <= 1'b0;
		end else begin
			cycle++;
			if (rsp_take) begin
				void'(rsp_data_q.pop_front());
				void'(rsp_due_q.pop_front());
			end
			if (req_take) begin
				if (req_we) begin
					cache_mem[req_addr[5:0]] = req_wdata;
				end else begin
					rsp_data_q.push_back(cache_mem[req_addr[5:0]]);
					rsp_due_q.push_back(cycle + 1 + int'($urandom % 6));
				end
			end
			dc_req_ready <= ($urandom % 10) < 7;
			if (rsp_data_q.size() > 0 && cycle >= rsp_due_q[0]) begin
				dc_rsp_valid <= 1'b1;
				dc_rsp_data <= rsp_data_q[0];
			end else begin
				dc_rsp_valid <= 1'b0;
			end
		end
	end

	initial begin
		int gap;
		int waited;
		logic [1:0] w;
		instr_t ins;
		void'($urandom(32'hf913_6ca8));
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("wb_valid", 32'(wb_valid), 32'd0);
		check_value("dc_req_valid", 32'(dc_req_valid), 32'd0);
		check_value("in_ready", 32'(in_ready), 32'd1);
		@(posedge clk);

		// Known start values for every pool register
		for (int wi = 0; wi < 4; wi++) begin
			for (int r = 1; r <= pool_regs; r++) begin
				ins = '0;
				ins.alu.opcode = op_addi;
				ins.alu.rd = 5'(r);
				ins.alu.imm = 13'($urandom);
				send_instr(2'(wi), ins);
			end
		end

		for (int i = 0; i < num_instrs; i++) begin
			gap = int'($urandom % 3);
			if (gap != 0) begin
				in_valid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			make_random_instr(w, ins);
			send_instr(w, ins);
		end
		in_valid <= 1'b0;

		waited = 0;
		while (outstanding != 0 && waited < timeout) begin
			@(posedge clk);
			waited++;
		end
		// Quiet period to catch late extra writebacks
		repeat (20) @(posedge clk);
		if (outstanding == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			fail_run($sformatf("%0d writebacks still missing after the drain", outstanding));
		end
	end

endmodule

// File: verilog/back_end.sv
module back_end #(
	parameter int num_warps = 4,
	localparam int warp_w = (num_warps > 1) ? $clog2(num_warps) : 1
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                in_valid,
	output logic                                in_ready,
	input  logic [warp_w-1:0]                   in_warp,
	input  logic [backend_pkg::xlen-1:0]        in_pc,
	input  backend_pkg::instr_t                 in_instr,
	output logic                                dc_req_valid,
	input  logic                                dc_req_ready,
	output logic                                dc_req_we,
	output logic [backend_pkg::xlen-1:0]        dc_req_addr,
	output logic [backend_pkg::xlen-1:0]        dc_req_wdata,
	input  logic                                dc_rsp_valid,
	output logic                                dc_rsp_ready,
	input  logic [backend_pkg::xlen-1:0]        dc_rsp_data,
	output logic                                wb_valid,
	output logic [warp_w-1:0]                   wb_warp,
	output logic [backend_pkg::xlen-1:0]        wb_pc,
	output logic [backend_pkg::reg_addr_w-1:0]  wb_rd,
	output logic [backend_pkg::xlen-1:0]        wb_data
);
	import backend_pkg::*;

	logic ex_valid, ex_ready;
	logic [warp_w-1:0] ex_warp;
	logic [xlen-1:0] ex_pc, ex_a, ex_b;
	opcode_t ex_op;
	logic [reg_addr_w-1:0] ex_rd;

	logic ls_valid, ls_ready, ls_store;
	logic [warp_w-1:0] ls_warp;
	logic [xlen-1:0] ls_pc, ls_addr_base, ls_wdata;
	logic [reg_addr_w-1:0] ls_rd;
	logic signed [off_w-1:0] ls_offset;

	logic exr_valid, exr_ready;
	logic [warp_w-1:0] exr_warp;
	logic [xlen-1:0] exr_pc, exr_data;
	logic [reg_addr_w-1:0] exr_rd;

	logic lsr_valid, lsr_ready;
	logic [warp_w-1:0] lsr_warp;
	logic [xlen-1:0] lsr_pc, lsr_data;
	logic [reg_addr_w-1:0] lsr_rd;

	gpr_stage #(.num_warps(num_warps)) u_gpr_stage (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_ready(in_ready), .in_warp(in_warp),
		.in_pc(in_pc), .in_instr(in_instr),
		.ex_valid(ex_valid), .ex_ready(ex_ready), .ex_warp(ex_warp), .ex_pc(ex_pc),
		.ex_op(ex_op), .ex_rd(ex_rd), .ex_a(ex_a), .ex_b(ex_b),
		.ls_valid(ls_valid), .ls_ready(ls_ready), .ls_warp(ls_warp), .ls_pc(ls_pc),
		.ls_store(ls_store), .ls_rd(ls_rd), .ls_addr_base(ls_addr_base),
		.ls_offset(ls_offset), .ls_wdata(ls_wdata),
		.wb_valid(wb_valid), .wb_warp(wb_warp), .wb_pc(wb_pc),
		.wb_rd(wb_rd), .wb_data(wb_data)
	);

	exec_unit #(.num_warps(num_warps)) u_exec_unit (
		.clk(clk), .rst_n(rst_n),
		.ex_valid(ex_valid), .ex_ready(ex_ready), .ex_warp(ex_warp), .ex_pc(ex_pc),
		.ex_op(ex_op), .ex_rd(ex_rd), .ex_a(ex_a), .ex_b(ex_b),
		.exr_valid(exr_valid), .exr_ready(exr_ready), .exr_warp(exr_warp),
		.exr_pc(exr_pc), .exr_rd(exr_rd), .exr_data(exr_data)
	);

	lsu #(.num_warps(num_warps)) u_lsu (
		.clk(clk), .rst_n(rst_n),
		.ls_valid(ls_valid), .ls_ready(ls_ready), .ls_warp(ls_warp), .ls_pc(ls_pc),
		.ls_store(ls_store), .ls_rd(ls_rd), .ls_addr_base(ls_addr_base),
		.ls_offset(ls_offset), .ls_wdata(ls_wdata),
		.dc_req_valid(dc_req_valid), .dc_req_ready(dc_req_ready), .dc_req_we(dc_req_we),
		.dc_req_addr(dc_req_addr), .dc_req_wdata(dc_req_wdata),
		.dc_rsp_valid(dc_rsp_valid), .dc_rsp_ready(dc_rsp_ready), .dc_rsp_data(dc_rsp_data),
		.lsr_valid(lsr_valid), .lsr_ready(lsr_ready), .lsr_warp(lsr_warp),
		.lsr_pc(lsr_pc), .lsr_rd(lsr_rd), .lsr_data(lsr_data)
	);

	writeback_arb #(.num_warps(num_warps)) u_writeback_arb (
		.clk(clk), .rst_n(rst_n),
		.exr_valid(exr_valid), .exr_ready(exr_ready), .exr_warp(exr_warp),
		.exr_pc(exr_pc), .exr_rd(exr_rd), .exr_data(exr_data),
		.lsr_valid(lsr_valid), .lsr_ready(lsr_ready), .lsr_warp(lsr_warp),
		.lsr_pc(lsr_pc), .lsr_rd(lsr_rd), .lsr_data(lsr_data),
		.wb_valid(wb_valid), .wb_warp(wb_warp), .wb_pc(wb_pc),
		.wb_rd(wb_rd), .wb_data(wb_data)
	);

endmodule

// File: verilog/backend_pkg.sv
package backend_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam int imm_w = 13;
	localparam int off_w = 18;

	typedef enum logic [3:0] {
		op_add  = 4'h0,
		op_sub  = 4'h1,
		op_and  = 4'h2,
		op_or   = 4'h3,
		op_xor  = 4'h4,
		op_sll  = 4'h5,
		op_srl  = 4'h6,
		op_slt  = 4'h7,
		op_addi = 4'h8,
		op_lw   = 4'h9,
		op_sw   = 4'ha
	} opcode_t;

	typedef struct packed {
		opcode_t                opcode;
		logic [reg_addr_w-1:0]  rd;
		logic [reg_addr_w-1:0]  rs1;
		logic [reg_addr_w-1:0]  rs2;
		logic [imm_w-1:0]       imm;
	} alu_fmt_t;

	// rd_rs2 is the load target or the store data register
	typedef struct packed {
		opcode_t                  opcode;
		logic [reg_addr_w-1:0]    rd_rs2;
		logic [reg_addr_w-1:0]    rs1;
		logic signed [off_w-1:0]  offset;
	} mem_fmt_t;

	typedef union packed {
		alu_fmt_t alu;
		mem_fmt_t mem;
	} instr_t;

	function automatic logic is_mem_op(opcode_t op);
		return (op == op_lw) || (op == op_sw);
	endfunction

endpackage

// File: verilog/exec_unit.sv
module exec_unit #(
	parameter int num_warps = 4,
	localparam int warp_w = (num_warps > 1) ? $clog2(num_warps) : 1
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                ex_valid,
	output logic                                ex_ready,
	input  logic [warp_w-1:0]                   ex_warp,
	input  logic [backend_pkg::xlen-1:0]        ex_pc,
	input  backend_pkg::opcode_t                ex_op,
	input  logic [backend_pkg::reg_addr_w-1:0]  ex_rd,
	input  logic [backend_pkg::xlen-1:0]        ex_a,
	input  logic [backend_pkg::xlen-1:0]        ex_b,
	output logic                                exr_valid,
	input  logic                                exr_ready,
	output logic [warp_w-1:0]                   exr_warp,
	output logic [backend_pkg::xlen-1:0]        exr_pc,
	output logic [backend_pkg::reg_addr_w-1:0]  exr_rd,
	output logic [backend_pkg::xlen-1:0]        exr_data
);
	import backend_pkg::*;

	localparam int shamt_w = $clog2(xlen);

	logic s1_valid;
	logic [warp_w-1:0] s1_warp;
	logic [xlen-1:0] s1_pc;
	opcode_t s1_op;
	logic [reg_addr_w-1:0] s1_rd;
	logic [xlen-1:0] s1_a;
	logic [xlen-1:0] s1_b;
	logic [xlen-1:0] s1_res;
	logic s2_valid;
	logic s2_free;
	logic s1_free;

	assign s2_free = !s2_valid || exr_ready;
	assign s1_free = !s1_valid || s2_free;
	assign ex_ready = s1_free;

	always_comb begin
		case (s1_op)
			op_sub:  s1_res = s1_a - s1_b;
			op_and:  s1_res = s1_a & s1_b;
			op_or:   s1_res = s1_a | s1_b;
			op_xor:  s1_res = s1_a ^ s1_b;
			op_sll:  s1_res = s1_a << s1_b[shamt_w-1:0];
			op_srl:  s1_res = s1_a >> s1_b[shamt_w-1:0];
			op_slt:  s1_res = {{(xlen-1){1'b0}}, $signed(s1_a) < $signed(s1_b)};
			// add, addi and any unknown code
			default: s1_res = s1_a + s1_b;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (s1_free)
				s1_valid <= ex_valid;
			if (s2_free)
				s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_free && ex_valid) begin
			s1_warp <= ex_warp;
			s1_pc <= ex_pc;
			s1_op <= ex_op;
			s1_rd <= ex_rd;
			s1_a <= ex_a;
			s1_b <= ex_b;
		end
		if (s2_free && s1_valid) begin
			exr_warp <= s1_warp;
			exr_pc <= s1_pc;
			exr_rd <= s1_rd;
			exr_data <= s1_res;
		end
	end

	assign exr_valid = s2_valid;

endmodule

// File: verilog/gpr_stage.sv
module gpr_stage #(
	parameter int num_warps = 4,
	localparam int warp_w = (num_warps > 1) ? $clog2(num_warps) : 1
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   in_valid,
	output logic                                   in_ready,
	input  logic [warp_w-1:0]                      in_warp,
	input  logic [backend_pkg::xlen-1:0]           in_pc,
	input  backend_pkg::instr_t                    in_instr,
	output logic                                   ex_valid,
	input  logic                                   ex_ready,
	output logic [warp_w-1:0]                      ex_warp,
	output logic [backend_pkg::xlen-1:0]           ex_pc,
	output backend_pkg::opcode_t                   ex_op,
	output logic [backend_pkg::reg_addr_w-1:0]     ex_rd,
	output logic [backend_pkg::xlen-1:0]           ex_a,
	output logic [backend_pkg::xlen-1:0]           ex_b,
	output logic                                   ls_valid,
	input  logic                                   ls_ready,
	output logic [warp_w-1:0]                      ls_warp,
	output logic [backend_pkg::xlen-1:0]           ls_pc,
	output logic                                   ls_store,
	output logic [backend_pkg::reg_addr_w-1:0]     ls_rd,
	output logic [backend_pkg::xlen-1:0]           ls_addr_base,
	output logic signed [backend_pkg::off_w-1:0]   ls_offset,
	output logic [backend_pkg::xlen-1:0]           ls_wdata,
	input  logic                                   wb_valid,
	input  logic [warp_w-1:0]                      wb_warp,
	input  logic [backend_pkg::xlen-1:0]           wb_pc,
	input  logic [backend_pkg::reg_addr_w-1:0]     wb_rd,
	input  logic [backend_pkg::xlen-1:0]           wb_data
);
	import backend_pkg::*;

	localparam int num_regs = 1 << reg_addr_w;

	logic [xlen-1:0] rf [num_warps][num_regs];
	logic [num_warps-1:0][num_regs-1:0] pending;
	logic [num_regs-1:0] pend_now;

	alu_fmt_t in_alu;
	mem_fmt_t in_mem;
	opcode_t in_op;
	logic in_is_mem;
	logic in_is_store;
	logic uses_rs2;
	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [reg_addr_w-1:0] rd;
	logic hazard;
	logic drain;
	logic fire;
	logic [xlen-1:0] a_val;
	logic [xlen-1:0] b_val;

	// Dispatch register
	logic d_valid;
	logic d_mem;
	logic [warp_w-1:0] d_warp;
	logic [xlen-1:0] d_pc;
	opcode_t d_op;
	logic [reg_addr_w-1:0] d_rd;
	logic [xlen-1:0] d_a;
	logic [xlen-1:0] d_b;
	logic signed [off_w-1:0] d_offset;

	function automatic logic [xlen-1:0] read_op(logic [reg_addr_w-1:0] r);
		logic [xlen-1:0] v;
		if (r == '0)
			v = '0;
		else if (wb_valid && wb_warp == in_warp && wb_rd == r)
			v = wb_data;
		else
			v = rf[in_warp][r];
		return v;
	endfunction

	assign in_alu = in_instr.alu;
	assign in_mem = in_instr.mem;
	assign in_op = in_alu.opcode;
	assign in_is_mem = is_mem_op(in_op);
	assign in_is_store = (in_op == op_sw);
	// rs1 and rd sit in the same bits in both formats
	assign rs1 = in_alu.rs1;
	assign rs2 = in_is_mem ? in_mem.rd_rs2 : in_alu.rs2;
	assign rd = in_alu.rd;
	assign uses_rs2 = in_is_store || (!in_is_mem && in_op != op_addi);

	// A writeback in this cycle already frees its register
	always_comb begin
		pend_now = pending[in_warp];
		if (wb_valid && wb_warp == in_warp)
			pend_now[wb_rd] = 1'b0;
	end

	assign hazard = pend_now[rs1] || pend_now[rd] || (uses_rs2 && pend_now[rs2]);
	assign drain = d_mem ? ls_ready : ex_ready;
	assign in_ready = (!d_valid || drain) && !hazard;
	assign fire = in_valid && in_ready;

	always_comb begin
		a_val = read_op(rs1);
		if (in_op == op_addi)
			b_val = {{(xlen-imm_w){in_alu.imm[imm_w-1]}}, in_alu.imm};
		else
			b_val = read_op(rs2);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			if (wb_valid)
				pending[wb_warp][wb_rd] <= 1'b0;
			if (fire && !in_is_store && rd != '0)
				pending[in_warp][rd] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wb_valid && wb_rd != '0)
			rf[wb_warp][wb_rd] <= wb_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			d_valid <= 1'b0;
			d_mem <= 1'b0;
		end else if (fire) begin
			d_valid <= 1'b1;
			d_mem <= in_is_mem;
		end else if (drain) begin
			d_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			d_warp <= in_warp;
			d_pc <= in_pc;
			d_op <= in_op;
			d_rd <= rd;
			d_a <= a_val;
			d_b <= b_val;
			d_offset <= in_mem.offset;
		end
	end

	assign ex_valid = d_valid && !d_mem;
	assign ex_warp = d_warp;
	assign ex_pc = d_pc;
	assign ex_op = d_op;
	assign ex_rd = d_rd;
	assign ex_a = d_a;
	assign ex_b = d_b;

	assign ls_valid = d_valid && d_mem;
	assign ls_warp = d_warp;
	assign ls_pc = d_pc;
	assign ls_store = (d_op == op_sw);
	assign ls_rd = d_rd;
	assign ls_addr_base = d_a;
	assign ls_offset = d_offset;
	assign ls_wdata = d_b;

endmodule

// File: verilog/lsu.sv
module lsu #(
	parameter int num_warps = 4,
	localparam int warp_w = (num_warps > 1) ? $clog2(num_warps) : 1
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  ls_valid,
	output logic                                  ls_ready,
	input  logic [warp_w-1:0]                     ls_warp,
	input  logic [backend_pkg::xlen-1:0]          ls_pc,
	input  logic                                  ls_store,
	input  logic [backend_pkg::reg_addr_w-1:0]    ls_rd,
	input  logic [backend_pkg::xlen-1:0]          ls_addr_base,
	input  logic signed [backend_pkg::off_w-1:0]  ls_offset,
	input  logic [backend_pkg::xlen-1:0]          ls_wdata,
	output logic                                  dc_req_valid,
	input  logic                                  dc_req_ready,
	output logic                                  dc_req_we,
	output logic [backend_pkg::xlen-1:0]          dc_req_addr,
	output logic [backend_pkg::xlen-1:0]          dc_req_wdata,
	input  logic                                  dc_rsp_valid,
	output logic                                  dc_rsp_ready,
	input  logic [backend_pkg::xlen-1:0]          dc_rsp_data,
	output logic                                  lsr_valid,
	input  logic                                  lsr_ready,
	output logic [warp_w-1:0]                     lsr_warp,
	output logic [backend_pkg::xlen-1:0]          lsr_pc,
	output logic [backend_pkg::reg_addr_w-1:0]    lsr_rd,
	output logic [backend_pkg::xlen-1:0]          lsr_data
);
	import backend_pkg::*;

	logic ls_fire;
	logic rsp_fire;
	logic push;

	// Tags of loads in flight with the oldest at q_head
	logic [warp_w-1:0] q_warp [2];
	logic [xlen-1:0] q_pc [2];
	logic [reg_addr_w-1:0] q_rd [2];
	logic q_head;
	logic q_tail;
	logic [1:0] q_count;

	assign ls_ready = (!dc_req_valid || dc_req_ready) && (q_count != 2'd2);
	assign ls_fire = ls_valid && ls_ready;
	assign push = ls_fire && !ls_store;
	assign dc_rsp_ready = !lsr_valid || lsr_ready;
	assign rsp_fire = dc_rsp_valid && dc_rsp_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dc_req_valid <= 1'b0;
		end else if (ls_fire) begin
			dc_req_valid <= 1'b1;
		end else if (dc_req_ready) begin
			dc_req_valid <= 1'b0;
		end
	end

	// Word address with the offset sign extended
	always_ff @(posedge clk) begin
		if (ls_fire) begin
			dc_req_we <= ls_store;
			dc_req_addr <= ls_addr_base + {{(xlen-off_w){ls_offset[off_w-1]}}, ls_offset};
			dc_req_wdata <= ls_wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q_head <= 1'b0;
			q_tail <= 1'b0;
			q_count <= 2'd0;
		end else begin
			if (push)
				q_tail <= !q_tail;
			if (rsp_fire)
				q_head <= !q_head;
			q_count <= q_count + 2'(push) - 2'(rsp_fire);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			q_warp[q_tail] <= ls_warp;
			q_pc[q_tail] <= ls_pc;
			q_rd[q_tail] <= ls_rd;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lsr_valid <= 1'b0;
		end else if (rsp_fire) begin
			lsr_valid <= 1'b1;
		end else if (lsr_ready) begin
			lsr_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_fire) begin
			lsr_warp <= q_warp[q_head];
			lsr_pc <= q_pc[q_head];
			lsr_rd <= q_rd[q_head];
			lsr_data <= dc_rsp_data;
		end
	end

endmodule

// File: verilog/writeback_arb.sv
module writeback_arb #(
	parameter int num_warps = 4,
	localparam int warp_w = (num_warps > 1) ? $clog2(num_warps) : 1
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                exr_valid,
	output logic                                exr_ready,
	input  logic [warp_w-1:0]                   exr_warp,
	input  logic [backend_pkg::xlen-1:0]        exr_pc,
	input  logic [backend_pkg::reg_addr_w-1:0]  exr_rd,
	input  logic [backend_pkg::xlen-1:0]        exr_data,
	input  logic                                lsr_valid,
	output logic                                lsr_ready,
	input  logic [warp_w-1:0]                   lsr_warp,
	input  logic [backend_pkg::xlen-1:0]        lsr_pc,
	input  logic [backend_pkg::reg_addr_w-1:0]  lsr_rd,
	input  logic [backend_pkg::xlen-1:0]        lsr_data,
	output logic                                wb_valid,
	output logic [warp_w-1:0]                   wb_warp,
	output logic [backend_pkg::xlen-1:0]        wb_pc,
	output logic [backend_pkg::reg_addr_w-1:0]  wb_rd,
	output logic [backend_pkg::xlen-1:0]        wb_data
);
	logic ex_grant;

	// Load results have priority
	assign lsr_ready = 1'b1;
	assign exr_ready = !lsr_valid;
	assign ex_grant = exr_valid && !lsr_valid;

	// Results for register 0 are consumed but never written back
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else
			wb_valid <= (lsr_valid && lsr_rd != '0) || (ex_grant && exr_rd != '0);
	end

	always_ff @(posedge clk) begin
		if (lsr_valid) begin
			wb_warp <= lsr_warp;
			wb_pc <= lsr_pc;
			wb_rd <= lsr_rd;
			wb_data <= lsr_data;
		end else if (ex_grant) begin
			wb_warp <= exr_warp;
			wb_pc <= exr_pc;
			wb_rd <= exr_rd;
			wb_data <= exr_data;
		end
	end

endmodule
